// ==== include/qspi_params.svh ====
`ifndef QSPI_PARAMS_SVH
`define QSPI_PARAMS_SVH

// Start of the memory-mapped flash window
`define QSPI_FLASH_BASE 32'h0000_1000

// Flash read command and its fixed data length
`define QSPI_READ_CMD 8'h03
`define QSPI_XIP_BITS 6'd32

`define QSPI_CLKDIV_RST 8'd4

// Register offsets inside the 4 KiB register page
`define QSPI_REG_CLKDIV 12'h000
`define QSPI_REG_CMD    12'h004
`define QSPI_REG_ADDR   12'h008
`define QSPI_REG_LEN    12'h00C
`define QSPI_REG_TXDATA 12'h010
`define QSPI_REG_RXDATA 12'h014
`define QSPI_REG_STATUS 12'h018
`define QSPI_REG_CS_DEF 12'h01C
`define QSPI_REG_CS_A0  12'h020
`define QSPI_REG_CS_M0  12'h024
`define QSPI_REG_CS_A1  12'h028
`define QSPI_REG_CS_M1  12'h02C

`endif

// ==== source/axi_lite_pkg.sv ====
package axi_lite_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // One enable per byte lane
  typedef logic [3:0] strb_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

endpackage

// ==== source/spi_flash_pkg.sv ====
package spi_flash_pkg;

  typedef logic [7:0]  opcode_t;
  typedef logic [23:0] flash_addr_t;
  typedef logic [3:0]  dummy_t;
  typedef logic [5:0]  data_len_t;
  typedef logic [7:0]  clkdiv_t;
  typedef logic        cs_idx_t;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_COMMAND,
    ENG_ADDRESS,
    ENG_DUMMY,
    ENG_DATA,
    ENG_FINISH
  } engine_state_t;

  typedef enum logic [1:0] {
    XIP_IDLE,
    XIP_WAIT,
    XIP_RESPOND
  } xip_state_t;

endpackage

// ==== source/qspi_regs.sv ====
`timescale 1ns/1ns
`include "qspi_params.svh"

module qspi_regs
  import axi_lite_pkg::*;
  import spi_flash_pkg::*;
(
  input  logic        s_axi_aclk,
  input  logic        s_axi_aresetn,
  input  logic        awvalid_i,
  input  addr_t       awaddr_i,
  input  logic        wvalid_i,
  input  data_t       wdata_i,
  input  strb_t       wstrb_i,
  input  logic        bready_i,
  input  logic        arvalid_i,
  input  addr_t       araddr_i,
  input  logic        rready_i,
  input  logic        busy_i,
  input  data_t       rx_data_i,
  output logic        awready_o,
  output logic        wready_o,
  output logic        bvalid_o,
  output resp_t       bresp_o,
  output logic        arready_o,
  output logic        rvalid_o,
  output data_t       rdata_o,
  output resp_t       rresp_o,
  output clkdiv_t     clkdiv_o,
  output logic        cpol_o,
  output opcode_t     cmd_o,
  output flash_addr_t addr_o,
  output logic        addr_en_o,
  output dummy_t      dummy_o,
  output data_len_t   data_len_o,
  output logic        write_o,
  output data_t       tx_data_o,
  output logic        trigger_o,
  output cs_idx_t     cs_def_o,
  output addr_t       cs_a0_o,
  output addr_t       cs_m0_o,
  output addr_t       cs_a1_o,
  output addr_t       cs_m1_o
);

  logic        wr_go;
  logic        wr_ok;
  logic        rd_go;
  logic        rd_ok;
  logic [11:0] wr_off;
  logic [11:0] rd_off;
  data_t       wr_word;

  // Current contents of a register as software sees it
  function automatic data_t reg_value(input logic [11:0] off);
    case (off)
      `QSPI_REG_CLKDIV: reg_value = {23'h0, cpol_o, clkdiv_o};
      `QSPI_REG_CMD:    reg_value = {24'h0, cmd_o};
      `QSPI_REG_ADDR:   reg_value = {8'h0, addr_o};
      `QSPI_REG_LEN: begin
        reg_value = {15'h0, write_o, dummy_o, 3'h0, addr_en_o, 2'h0, data_len_o};
      end
      `QSPI_REG_TXDATA: reg_value = tx_data_o;
      `QSPI_REG_RXDATA: reg_value = rx_data_i;
      `QSPI_REG_STATUS: reg_value = {31'h0, busy_i};
      `QSPI_REG_CS_DEF: reg_value = {31'h0, cs_def_o};
      `QSPI_REG_CS_A0:  reg_value = cs_a0_o;
      `QSPI_REG_CS_M0:  reg_value = cs_m0_o;
      `QSPI_REG_CS_A1:  reg_value = cs_a1_o;
      `QSPI_REG_CS_M1:  reg_value = cs_m1_o;
      default:          reg_value = '0;
    endcase
  endfunction

  // Offsets are word aligned and contiguous up to the last window mask
  function automatic logic reg_mapped(input logic [11:0] off);
    reg_mapped = (off[1:0] == 2'b00) && (off <= `QSPI_REG_CS_M1);
  endfunction

  function automatic data_t merge(input data_t old, input data_t wr_val, input strb_t strb);
    data_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = wr_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign wr_off  = awaddr_i[11:0];
  assign rd_off  = araddr_i[11:0];
  assign wr_ok   = (awaddr_i < `QSPI_FLASH_BASE) && reg_mapped(wr_off);
  assign rd_ok   = (araddr_i < `QSPI_FLASH_BASE) && reg_mapped(rd_off);
  assign wr_word = merge(reg_value(wr_off), wdata_i, wstrb_i);

  // AW and W are taken together, never while a response waits
  assign wr_go = awvalid_i && wvalid_i && !bvalid_o && !awready_o;
  assign rd_go = arvalid_i && !rvalid_o && !arready_o;

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      awready_o  <= 1'b0;
      wready_o   <= 1'b0;
      bvalid_o   <= 1'b0;
      bresp_o    <= RESP_OKAY;
      trigger_o  <= 1'b0;
      clkdiv_o   <= `QSPI_CLKDIV_RST;
      cpol_o     <= 1'b0;
      cmd_o      <= '0;
      addr_o     <= '0;
      addr_en_o  <= 1'b0;
      dummy_o    <= '0;
      data_len_o <= '0;
      write_o    <= 1'b0;
      tx_data_o  <= '0;
      cs_def_o   <= 1'b0;
      cs_a0_o    <= '0;
      cs_m0_o    <= '0;
      cs_a1_o    <= '0;
      cs_m1_o    <= '0;
    end else begin
      awready_o <= wr_go;
      wready_o  <= wr_go;
      trigger_o <= 1'b0;
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (awready_o) begin
        bvalid_o <= 1'b1;
        bresp_o  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        if (wr_ok) begin
          case (wr_off)
            `QSPI_REG_CLKDIV: begin
              clkdiv_o <= wr_word[7:0];
              cpol_o   <= wr_word[8];
            end
            `QSPI_REG_CMD:  cmd_o <= wr_word[7:0];
            `QSPI_REG_ADDR: addr_o <= wr_word[23:0];
            `QSPI_REG_LEN: begin
              data_len_o <= wr_word[5:0];
              addr_en_o  <= wr_word[8];
              dummy_o    <= wr_word[15:12];
              write_o    <= wr_word[16];
            end
            `QSPI_REG_TXDATA: tx_data_o <= wr_word;
            // Busy is read-only, bit 0 written as 1 starts a command
            `QSPI_REG_STATUS: trigger_o <= wstrb_i[0] & wdata_i[0];
            `QSPI_REG_CS_DEF: cs_def_o <= wr_word[0];
            `QSPI_REG_CS_A0:  cs_a0_o <= wr_word;
            `QSPI_REG_CS_M0:  cs_m0_o <= wr_word;
            `QSPI_REG_CS_A1:  cs_a1_o <= wr_word;
            `QSPI_REG_CS_M1:  cs_m1_o <= wr_word;
            default: ;
          endcase
        end
      end
    end
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      rresp_o   <= RESP_OKAY;
    end else begin
      arready_o <= rd_go;
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
      end
      if (arready_o) begin
        rvalid_o <= 1'b1;
        rdata_o  <= rd_ok ? reg_value(rd_off) : '0;
        rresp_o  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      end
    end
  end

endmodule

// ==== source/qspi_xip_reader.sv ====
`timescale 1ns/1ns
`include "qspi_params.svh"

module qspi_xip_reader
  import axi_lite_pkg::*;
  import spi_flash_pkg::*;
(
  input  logic        s_axi_aclk,
  input  logic        s_axi_aresetn,
  input  logic        arvalid_i,
  input  addr_t       araddr_i,
  input  logic        rready_i,
  input  logic        busy_i,
  input  logic        done_i,
  input  data_t       rx_data_i,
  input  cs_idx_t     cs_def_i,
  input  addr_t       cs_a0_i,
  input  addr_t       cs_m0_i,
  input  addr_t       cs_a1_i,
  input  addr_t       cs_m1_i,
  output logic        arready_o,
  output logic        rvalid_o,
  output data_t       rdata_o,
  output logic        start_o,
  output logic        active_o,
  output flash_addr_t flash_addr_o,
  output cs_idx_t     cs_idx_o
);

  xip_state_t state;
  addr_t      offset;
  cs_idx_t    cs_pick;
  logic       accept;

  assign offset = araddr_i - `QSPI_FLASH_BASE;

  // Window 0 wins over window 1, the default select catches the rest
  assign cs_pick = ((araddr_i & cs_m0_i) == cs_a0_i) ? 1'b0 :
                   ((araddr_i & cs_m1_i) == cs_a1_i) ? 1'b1 : cs_def_i;

  assign accept   = (state == XIP_IDLE) && arvalid_i && !busy_i;
  assign rvalid_o = (state == XIP_RESPOND);
  assign active_o = (state != XIP_IDLE);

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      state     <= XIP_IDLE;
      arready_o <= 1'b0;
      start_o   <= 1'b0;
    end else begin
      arready_o <= 1'b0;
      start_o   <= 1'b0;
      case (state)
        XIP_IDLE: begin
          if (accept) begin
            arready_o <= 1'b1;
            start_o   <= 1'b1;
            state     <= XIP_WAIT;
          end
        end
        XIP_WAIT: begin
          if (done_i) begin
            state <= XIP_RESPOND;
          end
        end
        XIP_RESPOND: begin
          if (rready_i) begin
            state <= XIP_IDLE;
          end
        end
        default: state <= XIP_IDLE;
      endcase
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (accept) begin
      flash_addr_o <= offset[23:0];
      cs_idx_o     <= cs_pick;
    end
    // First byte off the wire goes to the lowest lane
    if (state == XIP_WAIT && done_i) begin
      rdata_o <= {rx_data_i[7:0], rx_data_i[15:8], rx_data_i[23:16], rx_data_i[31:24]};
    end
  end

endmodule

// ==== source/spi_engine.sv ====
`timescale 1ns/1ns

module spi_engine
  import axi_lite_pkg::*;
  import spi_flash_pkg::*;
(
  input  logic        s_axi_aclk,
  input  logic        s_axi_aresetn,
  input  logic        start_i,
  input  clkdiv_t     clkdiv_i,
  input  logic        cpol_i,
  input  opcode_t     cmd_i,
  input  flash_addr_t addr_i,
  input  logic        addr_en_i,
  input  dummy_t      dummy_i,
  input  data_len_t   data_len_i,
  input  logic        write_i,
  input  data_t       tx_data_i,
  input  cs_idx_t     cs_idx_i,
  input  logic        spi_sdi_i,
  output logic        busy_o,
  output logic        done_o,
  output data_t       rx_data_o,
  output logic        spi_clk_o,
  output logic [1:0]  spi_csn_o,
  output logic        spi_sdo_o
);

  engine_state_t state;
  engine_state_t next_phase;
  clkdiv_t       div_cnt;
  logic          sclk_q;
  data_len_t     bits_left;
  data_t         shift_q;

  assign busy_o    = (state != ENG_IDLE);
  assign done_o    = (state == ENG_FINISH);
  assign spi_clk_o = cpol_i ^ sclk_q;

  // Phase after the current one, skipping the empty ones
  always_comb begin
    next_phase = ENG_FINISH;
    if (state == ENG_COMMAND && addr_en_i) begin
      next_phase = ENG_ADDRESS;
    end else if ((state == ENG_COMMAND || state == ENG_ADDRESS) && dummy_i != '0) begin
      next_phase = ENG_DUMMY;
    end else if (state != ENG_DATA && data_len_i != '0) begin
      next_phase = ENG_DATA;
    end
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      state     <= ENG_IDLE;
      div_cnt   <= '0;
      sclk_q    <= 1'b0;
      bits_left <= '0;
      shift_q   <= '0;
      rx_data_o <= '0;
      spi_csn_o <= 2'b11;
      spi_sdo_o <= 1'b0;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (start_i) begin
            state     <= ENG_COMMAND;
            div_cnt   <= '0;
            bits_left <= 6'd8;
            shift_q   <= {cmd_i, 24'h0};
            rx_data_o <= '0;
            spi_csn_o <= ~(2'b01 << cs_idx_i);
          end
        end
        ENG_FINISH: begin
          state     <= ENG_IDLE;
          spi_csn_o <= 2'b11;
        end
        default: begin
          if (div_cnt != clkdiv_i) begin
            div_cnt <= div_cnt + 8'd1;
          end else begin
            div_cnt <= '0;
            sclk_q  <= ~sclk_q;
            if (!sclk_q) begin
              // Leading edge puts the next bit out
              spi_sdo_o <= shift_q[31];
              shift_q   <= {shift_q[30:0], 1'b0};
            end else begin
              // Trailing edge samples and closes the bit
              if (state == ENG_DATA && !write_i) begin
                rx_data_o <= {rx_data_o[30:0], spi_sdi_i};
              end
              if (bits_left != 6'd1) begin
                bits_left <= bits_left - 6'd1;
              end else begin
                state <= next_phase;
                case (next_phase)
                  ENG_ADDRESS: begin
                    bits_left <= 6'd24;
                    shift_q   <= {addr_i, 8'h0};
                  end
                  ENG_DUMMY: begin
                    bits_left <= {2'b00, dummy_i};
                    shift_q   <= '0;
                  end
                  ENG_DATA: begin
                    bits_left <= data_len_i;
                    shift_q   <= tx_data_i;
                  end
                  default: ;
                endcase
              end
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== source/axi_qspi_controller.sv ====
`timescale 1ns/1ns
`include "qspi_params.svh"

module axi_qspi_controller
  import axi_lite_pkg::*;
  import spi_flash_pkg::*;
(
  input  logic       s_axi_aclk,
  input  logic       s_axi_aresetn,
  input  logic       s_axi_awvalid_i,
  input  addr_t      s_axi_awaddr_i,
  output logic       s_axi_awready_o,
  input  logic       s_axi_wvalid_i,
  input  data_t      s_axi_wdata_i,
  input  strb_t      s_axi_wstrb_i,
  output logic       s_axi_wready_o,
  output logic       s_axi_bvalid_o,
  output resp_t      s_axi_bresp_o,
  input  logic       s_axi_bready_i,
  input  logic       s_axi_arvalid_i,
  input  addr_t      s_axi_araddr_i,
  output logic       s_axi_arready_o,
  output logic       s_axi_rvalid_o,
  output data_t      s_axi_rdata_o,
  output resp_t      s_axi_rresp_o,
  input  logic       s_axi_rready_i,
  output logic       spi_clk_o,
  output logic [1:0] spi_csn_o,
  output logic       spi_sdo_o,
  input  logic       spi_sdi_i
);

  logic        reg_sel;
  logic        regs_arready;
  logic        regs_rvalid;
  data_t       regs_rdata;
  resp_t       regs_rresp;
  logic        xip_arready;
  logic        xip_rvalid;
  data_t       xip_rdata;
  logic        xip_start;
  logic        xip_active;
  flash_addr_t xip_addr;
  cs_idx_t     xip_cs;
  clkdiv_t     clkdiv;
  logic        cpol;
  opcode_t     reg_cmd;
  flash_addr_t reg_addr;
  logic        reg_addr_en;
  dummy_t      reg_dummy;
  data_len_t   reg_len;
  logic        reg_write;
  data_t       tx_data;
  logic        trigger;
  cs_idx_t     cs_def;
  addr_t       cs_a0;
  addr_t       cs_m0;
  addr_t       cs_a1;
  addr_t       cs_m1;
  logic        busy;
  logic        done;
  data_t       rx_data;

  assign reg_sel = (s_axi_araddr_i < `QSPI_FLASH_BASE);

  assign s_axi_arready_o = reg_sel ? regs_arready : xip_arready;

  // Single outstanding read, so at most one side holds rvalid
  assign s_axi_rvalid_o = regs_rvalid | xip_rvalid;
  assign s_axi_rdata_o  = regs_rvalid ? regs_rdata : xip_rdata;
  assign s_axi_rresp_o  = regs_rvalid ? regs_rresp : RESP_OKAY;

  qspi_regs u_regs (
    .s_axi_aclk   (s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .awvalid_i    (s_axi_awvalid_i),
    .awaddr_i     (s_axi_awaddr_i),
    .wvalid_i     (s_axi_wvalid_i),
    .wdata_i      (s_axi_wdata_i),
    .wstrb_i      (s_axi_wstrb_i),
    .bready_i     (s_axi_bready_i),
    .arvalid_i    (s_axi_arvalid_i && reg_sel && !xip_rvalid),
    .araddr_i     (s_axi_araddr_i),
    .rready_i     (s_axi_rready_i),
    .busy_i       (busy),
    .rx_data_i    (rx_data),
    .awready_o    (s_axi_awready_o),
    .wready_o     (s_axi_wready_o),
    .bvalid_o     (s_axi_bvalid_o),
    .bresp_o      (s_axi_bresp_o),
    .arready_o    (regs_arready),
    .rvalid_o     (regs_rvalid),
    .rdata_o      (regs_rdata),
    .rresp_o      (regs_rresp),
    .clkdiv_o     (clkdiv),
    .cpol_o       (cpol),
    .cmd_o        (reg_cmd),
    .addr_o       (reg_addr),
    .addr_en_o    (reg_addr_en),
    .dummy_o      (reg_dummy),
    .data_len_o   (reg_len),
    .write_o      (reg_write),
    .tx_data_o    (tx_data),
    .trigger_o    (trigger),
    .cs_def_o     (cs_def),
    .cs_a0_o      (cs_a0),
    .cs_m0_o      (cs_m0),
    .cs_a1_o      (cs_a1),
    .cs_m1_o      (cs_m1)
  );

  qspi_xip_reader u_xip (
    .s_axi_aclk   (s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .arvalid_i    (s_axi_arvalid_i && !reg_sel && !regs_rvalid),
    .araddr_i     (s_axi_araddr_i),
    .rready_i     (s_axi_rready_i),
    .busy_i       (busy),
    .done_i       (done),
    .rx_data_i    (rx_data),
    .cs_def_i     (cs_def),
    .cs_a0_i      (cs_a0),
    .cs_m0_i      (cs_m0),
    .cs_a1_i      (cs_a1),
    .cs_m1_i      (cs_m1),
    .arready_o    (xip_arready),
    .rvalid_o     (xip_rvalid),
    .rdata_o      (xip_rdata),
    .start_o      (xip_start),
    .active_o     (xip_active),
    .flash_addr_o (xip_addr),
    .cs_idx_o     (xip_cs)
  );

  // Flash reads own the command fields until their response is taken
  spi_engine u_engine (
    .s_axi_aclk   (s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .start_i      (xip_start | trigger),
    .clkdiv_i     (clkdiv),
    .cpol_i       (cpol),
    .cmd_i        (xip_active ? `QSPI_READ_CMD : reg_cmd),
    .addr_i       (xip_active ? xip_addr : reg_addr),
    .addr_en_i    (xip_active | reg_addr_en),
    .dummy_i      (xip_active ? 4'h0 : reg_dummy),
    .data_len_i   (xip_active ? `QSPI_XIP_BITS : reg_len),
    .write_i      (!xip_active && reg_write),
    .tx_data_i    (tx_data),
    .cs_idx_i     (xip_active ? xip_cs : cs_def),
    .spi_sdi_i    (spi_sdi_i),
    .busy_o       (busy),
    .done_o       (done),
    .rx_data_o    (rx_data),
    .spi_clk_o    (spi_clk_o),
    .spi_csn_o    (spi_csn_o),
    .spi_sdo_o    (spi_sdo_o)
  );

endmodule

// ==== test/spi_flash_model.sv ====
`timescale 1ns/1ns

// Single-lane SPI flash with a 256-byte array, answers 03h, 02h and 9Fh
module spi_flash_model #(
  parameter logic [7:0] INIT_XOR = 8'hA5
) (
  input  logic sck_i,
  input  logic csn_i,
  input  logic si_i,
  output logic so_o
);

  logic [7:0]  mem [256];
  logic [7:0]  opcode;
  logic [23:0] addr_q;
  logic [7:0]  wr_byte;
  logic        lead_next;
  logic        out_q;
  int          bit_cnt;

  // Bit n of the reply, counted from the first opcode bit
  function automatic logic read_bit(input int n);
    int         idx;
    logic [7:0] b;
    logic [7:0] ma;
    idx = 0;
    b   = 8'h00;
    if (opcode == 8'h9F && n >= 8) begin
      idx = n - 8;
      case ((idx / 8) % 3)
        0:       b = 8'hC2;
        1:       b = 8'h20;
        default: b = 8'h18;
      endcase
    end else if (opcode == 8'h03 && n >= 32) begin
      idx = n - 32;
      ma  = addr_q[7:0] + 8'(idx / 8);
      b   = mem[ma];
    end
    b = b << (idx % 8);
    return b[7];
  endfunction

  initial begin
    for (int a = 0; a < 256; a++) begin
      mem[a] = 8'(a) ^ INIT_XOR;
    end
    opcode    = 8'h00;
    addr_q    = '0;
    wr_byte   = 8'h00;
    lead_next = 1'b1;
    out_q     = 1'b0;
    bit_cnt   = 0;
  end

  assign so_o = !csn_i && out_q;

  // First edge after select is the leading one, then edges alternate
  always @(posedge sck_i or negedge sck_i or posedge csn_i) begin
    if (csn_i) begin
      bit_cnt   = 0;
      lead_next = 1'b1;
      out_q     = 1'b0;
      opcode    = 8'h00;
    end else if (lead_next) begin
      out_q     = read_bit(bit_cnt);
      lead_next = 1'b0;
    end else begin
      if (bit_cnt < 8) begin
        opcode = {opcode[6:0], si_i};
      end else if (bit_cnt < 32 && opcode != 8'h9F) begin
        addr_q = {addr_q[22:0], si_i};
      end else if (opcode == 8'h02) begin
        wr_byte = {wr_byte[6:0], si_i};
        if (bit_cnt % 8 == 7) begin
          mem[addr_q[7:0]] = wr_byte;
          addr_q = addr_q + 24'd1;
        end
      end
      bit_cnt++;
      lead_next = 1'b1;
    end
  end

endmodule

// ==== test/axi_qspi_controller_asserts.sv ====
`timescale 1ns/1ns

module axi_qspi_controller_asserts (
  input logic        s_axi_aclk,
  input logic        s_axi_aresetn,
  input logic [1:0]  spi_csn_i,
  input logic        spi_clk_i,
  input logic        cpol_i,
  input logic        bvalid_i,
  input logic        bready_i,
  input logic [1:0]  bresp_i,
  input logic        rvalid_i,
  input logic        rready_i,
  input logic [31:0] rdata_i
);

  // Only one flash may be selected at a time
  a_single_cs: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    spi_csn_i != 2'b00)
    else $error("Both chip selects are low");

  a_b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("Write response changed before bready");

  a_r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("Read response changed before rready");

  // SPI clock rests at its polarity between commands
  a_clk_idle: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    spi_csn_i == 2'b11 |-> spi_clk_i == cpol_i)
    else $error("SPI clock left its idle level while deselected");

endmodule

// ==== test/tb_axi_qspi_controller.sv ====
`timescale 1ns/1ns
`include "qspi_params.svh"

module tb_axi_qspi_controller
  import axi_lite_pkg::*;
();

  localparam int      CLK_PERIOD     = 40;
  localparam int      TIMEOUT_CYCLES = 4000;
  localparam int      POLL_LIMIT     = 500;
  localparam addr_t   WIN0_BASE      = 32'h0000_1000;
  localparam addr_t   WIN1_BASE      = 32'h0000_1080;
  localparam addr_t   WIN_MASK       = 32'hFFFF_F080;

  logic       s_axi_aclk = 1'b0;
  logic       s_axi_aresetn;
  logic       awvalid;
  addr_t      awaddr;
  logic       awready;
  logic       wvalid;
  data_t      wdata;
  strb_t      wstrb;
  logic       wready;
  logic       bvalid;
  resp_t      bresp;
  logic       bready;
  logic       arvalid;
  addr_t      araddr;
  logic       arready;
  logic       rvalid;
  data_t      rdata;
  resp_t      rresp;
  logic       rready;
  logic       spi_clk;
  logic [1:0] spi_csn;
  logic       spi_sdo;
  logic       flash0_so;
  logic       flash1_so;
  integer     seed = 32'h28aa_f5a1;

  always #(CLK_PERIOD / 2) s_axi_aclk = ~s_axi_aclk;

  axi_qspi_controller u_dut (
    .s_axi_aclk     (s_axi_aclk),
    .s_axi_aresetn  (s_axi_aresetn),
    .s_axi_awvalid_i(awvalid),
    .s_axi_awaddr_i (awaddr),
    .s_axi_awready_o(awready),
    .s_axi_wvalid_i (wvalid),
    .s_axi_wdata_i  (wdata),
    .s_axi_wstrb_i  (wstrb),
    .s_axi_wready_o (wready),
    .s_axi_bvalid_o (bvalid),
    .s_axi_bresp_o  (bresp),
    .s_axi_bready_i (bready),
    .s_axi_arvalid_i(arvalid),
    .s_axi_araddr_i (araddr),
    .s_axi_arready_o(arready),
    .s_axi_rvalid_o (rvalid),
    .s_axi_rdata_o  (rdata),
    .s_axi_rresp_o  (rresp),
    .s_axi_rready_i (rready),
    .spi_clk_o      (spi_clk),
    .spi_csn_o      (spi_csn),
    .spi_sdo_o      (spi_sdo),
    .spi_sdi_i      (flash0_so | flash1_so)
  );

  spi_flash_model #(.INIT_XOR(8'hA5)) u_flash0 (
    .sck_i(spi_clk),
    .csn_i(spi_csn[0]),
    .si_i (spi_sdo),
    .so_o (flash0_so)
  );

  spi_flash_model #(.INIT_XOR(8'h5A)) u_flash1 (
    .sck_i(spi_clk),
    .csn_i(spi_csn[1]),
    .si_i (spi_sdo),
    .so_o (flash1_so)
  );

  bind axi_qspi_controller axi_qspi_controller_asserts u_asserts (
    .s_axi_aclk   (s_axi_aclk),
    .s_axi_aresetn(s_axi_aresetn),
    .spi_csn_i    (spi_csn_o),
    .spi_clk_i    (spi_clk_o),
    .cpol_i       (cpol),
    .bvalid_i     (s_axi_bvalid_o),
    .bready_i     (s_axi_bready_i),
    .bresp_i      (s_axi_bresp_o),
    .rvalid_i     (s_axi_rvalid_o),
    .rready_i     (s_axi_rready_i),
    .rdata_i      (s_axi_rdata_o)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic addr_t reg_addr(input logic [11:0] off);
    return {20'h0, off};
  endfunction

  // Word a flash read should return, first flash byte in the lowest lane
  function automatic data_t expected_word(input addr_t addr);
    addr_t      off;
    logic [7:0] xor_val;
    data_t      word;
    off     = addr - `QSPI_FLASH_BASE;
    xor_val = ((addr & WIN_MASK) == WIN0_BASE) ? 8'hA5 : 8'h5A;
    word    = '0;
    for (int k = 0; k < 4; k++) begin
      word[8*k +: 8] = (off[7:0] + 8'(k)) ^ xor_val;
    end
    return word;
  endfunction

  task automatic bus_write(input addr_t addr, input data_t data, input strb_t strb,
                           output resp_t resp);
    int cycles;
    @(posedge s_axi_aclk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    cycles = 0;
    @(negedge s_axi_aclk);
    while (!(awready && wready)) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run("Timeout waiting for the write address and data handshake");
      end
      @(negedge s_axi_aclk);
    end
    @(posedge s_axi_aclk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    cycles = 0;
    @(negedge s_axi_aclk);
    while (!bvalid) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run("Timeout waiting for the write response");
      end
      @(negedge s_axi_aclk);
    end
    resp = bresp;
    // Response waits one cycle with bready low before it is taken
    @(posedge s_axi_aclk);
    bready <= 1'b1;
    @(posedge s_axi_aclk);
    bready <= 1'b0;
  endtask

  // Hold keeps rready low for that many cycles once rvalid is up
  task automatic bus_read(input addr_t addr, input int hold, output data_t data,
                          output resp_t resp);
    int cycles;
    @(posedge s_axi_aclk);
    arvalid <= 1'b1;
    araddr  <= addr;
    rready  <= (hold == 0);
    cycles = 0;
    @(negedge s_axi_aclk);
    while (!arready) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run("Timeout waiting for the read address handshake");
      end
      @(negedge s_axi_aclk);
    end
    @(posedge s_axi_aclk);
    arvalid <= 1'b0;
    cycles = 0;
    @(negedge s_axi_aclk);
    while (!rvalid) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run("Timeout waiting for the read data");
      end
      @(negedge s_axi_aclk);
    end
    data = rdata;
    resp = rresp;
    for (int i = 0; i < hold; i++) begin
      @(negedge s_axi_aclk);
      if (!rvalid) begin
        abort_run("Read data was withdrawn while rready was low");
      end
      check_value("s_axi_rdata_o", rdata, data);
    end
    if (hold != 0) begin
      @(posedge s_axi_aclk);
      rready <= 1'b1;
    end
    @(posedge s_axi_aclk);
    rready <= 1'b0;
  endtask

  task automatic write_ok(input logic [11:0] off, input data_t data, input strb_t strb);
    resp_t resp;
    bus_write(reg_addr(off), data, strb, resp);
    check_value("s_axi_bresp_o", 32'(resp), 32'(RESP_OKAY));
  endtask

  task automatic read_expect(input addr_t addr, input int hold, input data_t exp);
    data_t data;
    resp_t resp;
    bus_read(addr, hold, data, resp);
    check_value("s_axi_rresp_o", 32'(resp), 32'(RESP_OKAY));
    check_value("s_axi_rdata_o", data, exp);
  endtask

  task automatic wait_not_busy();
    int    polls;
    data_t status;
    resp_t resp;
    polls = 0;
    bus_read(reg_addr(`QSPI_REG_STATUS), 0, status, resp);
    while (status[0]) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        abort_run("SPI engine stayed busy past the polling limit");
      end
      bus_read(reg_addr(`QSPI_REG_STATUS), 0, status, resp);
    end
  endtask

  task automatic reset_values();
    @(negedge s_axi_aclk);
    check_value("s_axi_awready_o", 32'(awready), 32'h0);
    check_value("s_axi_wready_o", 32'(wready), 32'h0);
    check_value("s_axi_bvalid_o", 32'(bvalid), 32'h0);
    check_value("s_axi_arready_o", 32'(arready), 32'h0);
    check_value("s_axi_rvalid_o", 32'(rvalid), 32'h0);
    check_value("spi_csn_o", 32'(spi_csn), 32'h3);
    check_value("spi_clk_o", 32'(spi_clk), 32'h0);
    read_expect(reg_addr(`QSPI_REG_CLKDIV), 0, 32'h0000_0004);
  endtask

  task automatic register_access();
    resp_t resp;
    write_ok(`QSPI_REG_CMD, 32'hA5A5_A59F, 4'hF);
    read_expect(reg_addr(`QSPI_REG_CMD), 0, 32'h0000_009F);
    write_ok(`QSPI_REG_TXDATA, 32'h1122_3344, 4'hF);
    write_ok(`QSPI_REG_TXDATA, 32'hAABB_CCDD, 4'b0101);
    read_expect(reg_addr(`QSPI_REG_TXDATA), 1, 32'h11BB_33DD);
    // Lane 1 holds CPOL, so it stays clear
    write_ok(`QSPI_REG_CLKDIV, 32'hFFFF_FF07, 4'b0001);
    read_expect(reg_addr(`QSPI_REG_CLKDIV), 0, 32'h0000_0007);
    write_ok(`QSPI_REG_CLKDIV, 32'h0000_0004, 4'hF);
    write_ok(`QSPI_REG_LEN, 32'h0001_F13F, 4'hF);
    read_expect(reg_addr(`QSPI_REG_LEN), 0, 32'h0001_F13F);
    write_ok(`QSPI_REG_LEN, 32'h0000_0000, 4'hF);
    write_ok(`QSPI_REG_CS_A1, 32'h1234_5678, 4'hF);
    read_expect(reg_addr(`QSPI_REG_CS_A1), 2, 32'h1234_5678);
    bus_write(32'h0000_1000, 32'h0, 4'hF, resp);
    check_value("s_axi_bresp_o", 32'(resp), 32'(RESP_SLVERR));
    bus_write(32'h0000_0040, 32'h0, 4'hF, resp);
    check_value("s_axi_bresp_o", 32'(resp), 32'(RESP_SLVERR));
  endtask

  task automatic flash_window_reads();
    addr_t addr;
    write_ok(`QSPI_REG_CS_A0, WIN0_BASE, 4'hF);
    write_ok(`QSPI_REG_CS_M0, WIN_MASK, 4'hF);
    write_ok(`QSPI_REG_CS_A1, WIN1_BASE, 4'hF);
    write_ok(`QSPI_REG_CS_M1, WIN_MASK, 4'hF);
    for (int i = 0; i < 12; i++) begin
      addr = `QSPI_FLASH_BASE + (32'($random(seed)) & 32'h0000_0FFC);
      read_expect(addr, (i % 3 == 2) ? 3 : 0, expected_word(addr));
    end
  endtask

  task automatic jedec_id_command();
    write_ok(`QSPI_REG_CS_DEF, 32'h0, 4'hF);
    write_ok(`QSPI_REG_CMD, 32'h0000_009F, 4'hF);
    write_ok(`QSPI_REG_LEN, 32'h0000_0018, 4'hF);
    write_ok(`QSPI_REG_STATUS, 32'h0000_0001, 4'hF);
    wait_not_busy();
    read_expect(reg_addr(`QSPI_REG_RXDATA), 0, 32'h00C2_2018);
    // RX word is read-only, the ID stays in place
    write_ok(`QSPI_REG_RXDATA, 32'hFFFF_FFFF, 4'hF);
    read_expect(reg_addr(`QSPI_REG_RXDATA), 0, 32'h00C2_2018);
  endtask

  task automatic program_then_read();
    data_t tx_word;
    data_t exp;
    tx_word = 32'hDEAD_BEEF;
    exp     = '0;
    write_ok(`QSPI_REG_CLKDIV, 32'h0000_0101, 4'hF);
    read_expect(reg_addr(`QSPI_REG_CLKDIV), 0, 32'h0000_0101);
    write_ok(`QSPI_REG_CMD, 32'h0000_0002, 4'hF);
    write_ok(`QSPI_REG_ADDR, 32'h0000_0010, 4'hF);
    // 32 data bits, address phase on, write direction
    write_ok(`QSPI_REG_LEN, 32'h0001_0120, 4'hF);
    write_ok(`QSPI_REG_TXDATA, tx_word, 4'hF);
    write_ok(`QSPI_REG_STATUS, 32'h0000_0001, 4'hF);
    wait_not_busy();
    for (int k = 0; k < 4; k++) begin
      exp[8*k +: 8] = tx_word[31 - 8*k -: 8];
    end
    read_expect(32'h0000_1010, 2, exp);
    read_expect(32'h0000_1014, 0, expected_word(32'h0000_1014));
  endtask

  initial begin
    s_axi_aresetn = 1'b0;
    awvalid       = 1'b0;
    awaddr        = '0;
    wvalid        = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    bready        = 1'b0;
    arvalid       = 1'b0;
    araddr        = '0;
    rready        = 1'b0;
    repeat (3) @(posedge s_axi_aclk);
    s_axi_aresetn <= 1'b1;
    reset_values();
    register_access();
    flash_window_reads();
    jedec_id_command();
    program_then_read();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== axi_qspi_controller.f ====
+incdir+include
source/axi_lite_pkg.sv
source/spi_flash_pkg.sv
source/qspi_regs.sv
source/qspi_xip_reader.sv
source/spi_engine.sv
source/axi_qspi_controller.sv
test/spi_flash_model.sv
test/axi_qspi_controller_asserts.sv
test/tb_axi_qspi_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f axi_qspi_controller.f \
  --top-module tb_axi_qspi_controller \
  --Mdir obj_dir -o tb_sim

output=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
